/* filelist.f */
+incdir+include
logic/board_ctrl_pkg.sv
logic/reg_bus_if.sv
logic/spi_slave.sv
logic/board_ctrl_regs.sv
logic/led_blink.sv
logic/board_ctrl_top.sv
sim/board_ctrl_assertions.sv
sim/tb_board_ctrl.sv

/* include/board_ctrl_defines.svh */
/* Register map and identity constants for the board-control block.
   One address map serves reads and writes, addresses are word indexes.
   Two-word values sit low word first. */
`ifndef BOARD_CTRL_DEFINES_SVH
`define BOARD_CTRL_DEFINES_SVH

// ----------------------------------------------------------------------
// field widths
// ----------------------------------------------------------------------
`define BC_REG_DWIDTH        16     // register word
`define BC_REG_AWIDTH        8      // register address
`define BC_SPI_FRAME_BITS    24     // r/w flag + 7 bit addr + data word
`define BC_ETH_COUNT         4      // ethernet ports
`define BC_ERR_CNT_WIDTH     32     // crc error counter
`define BC_LINK_CH_COUNT     2      // serial link channels

// ----------------------------------------------------------------------
// firmware identity
// ----------------------------------------------------------------------
`define BC_FW_DATE           32'hC0DE_0001
`define BC_FW_TIME           32'h0000_4B1D
`define BC_FW_TYPE           16'h00A5

// ----------------------------------------------------------------------
// register addresses
// ----------------------------------------------------------------------
`define BC_REG_FW_DATE       8'h00  // two words
`define BC_REG_FW_TIME       8'h02  // two words
`define BC_REG_FW_TYPE       8'h04
`define BC_REG_MAC_LINK      8'h05
`define BC_REG_RXERR0        8'h06  // ports 1..3 follow, two words each
`define BC_REG_PHY_RST       8'h0E
`define BC_REG_MDIO_CLK      8'h0F
`define BC_REG_MDIO_DOUT     8'h10
`define BC_REG_MDIO_DIR      8'h11
`define BC_REG_MDIO_DIN      8'h12
`define BC_REG_LINK_STATUS   8'h13
`define BC_REG_TEST_ARRAY    8'h20
`define BC_TEST_ARRAY_COUNT  8

`endif

/* logic/board_ctrl_pkg.sv */
/* Shared types of the board-control block.
   Widths come from the defines header. */
`default_nettype none

`include "board_ctrl_defines.svh"

package board_ctrl_pkg;

    typedef logic [`BC_REG_AWIDTH-1:0]    reg_addr_t;    // register address
    typedef logic [`BC_REG_DWIDTH-1:0]    reg_data_t;    // register word
    typedef logic [`BC_ERR_CNT_WIDTH-1:0] err_cnt_t;     // crc error count
    typedef logic [`BC_ETH_COUNT-1:0]     eth_bits_t;    // one bit per port

    // spi frame phases
    typedef enum logic [1:0] {
        SPI_IDLE,       // cs high or between frames
        SPI_ADDR,       // r/w flag and address bits
        SPI_WDATA,      // write data bits
        SPI_RDATA       // read data on miso
    } spi_state_e;

endpackage

`default_nettype wire

/* logic/board_ctrl_regs.sv */
/* Register bank behind the SPI slave. Status inputs are read as they
   are, only the MDIO input is resynchronized. Unmapped reads give 0. */
`timescale 1ns/1ps
`default_nettype none

`include "board_ctrl_defines.svh"

module board_ctrl_regs (
    input  wire                             reg_clk,
    input  wire                             arst_n_i,
    reg_bus_if.slave                        bus,
    input  wire board_ctrl_pkg::eth_bits_t  mac_link_i,
    input  wire board_ctrl_pkg::err_cnt_t   mac_rx_cnterr_i [0:`BC_ETH_COUNT-1],
    input  wire [`BC_LINK_CH_COUNT-1:0]     link_channel_up_i,
    input  wire                             eth_phy_mdio_i,
    output board_ctrl_pkg::eth_bits_t       eth_phy_rst_o,
    output logic                            eth_phy_mdc_o,
    output logic                            eth_phy_mdio_o,
    output logic                            eth_phy_mdio_oe_o
);

    localparam int unsigned DW = `BC_REG_DWIDTH;
    localparam logic [2*DW-1:0] FW_DATE = `BC_FW_DATE;
    localparam logic [2*DW-1:0] FW_TIME = `BC_FW_TIME;

    board_ctrl_pkg::reg_data_t test_array [0:`BC_TEST_ARRAY_COUNT-1];
    board_ctrl_pkg::reg_data_t rd_word;
    logic [1:0]                mdio_ff;

    function automatic logic wr_hit(input board_ctrl_pkg::reg_addr_t addr);
        return bus.wr_en && (bus.wr_addr == addr);
    endfunction

    // ------------------------------------------------------------------
    // writable registers
    // ------------------------------------------------------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            eth_phy_rst_o     <= '0;
            eth_phy_mdc_o     <= 1'b0;
            eth_phy_mdio_o    <= 1'b0;
            eth_phy_mdio_oe_o <= 1'b0;
            mdio_ff           <= 2'b00;
            for (int i = 0; i < `BC_TEST_ARRAY_COUNT; i++) begin
                test_array[i] <= '0;
            end
        end else begin
            mdio_ff <= {mdio_ff[0], eth_phy_mdio_i};
            if (wr_hit(`BC_REG_PHY_RST)) begin
                eth_phy_rst_o <= bus.wr_data[`BC_ETH_COUNT-1:0];
            end
            if (wr_hit(`BC_REG_MDIO_CLK)) begin
                eth_phy_mdc_o <= bus.wr_data[0];      // bit-banged mdc
            end
            if (wr_hit(`BC_REG_MDIO_DOUT)) begin
                eth_phy_mdio_o <= bus.wr_data[0];
            end
            if (wr_hit(`BC_REG_MDIO_DIR)) begin
                eth_phy_mdio_oe_o <= bus.wr_data[0];  // 1 drives the pad
            end
            for (int i = 0; i < `BC_TEST_ARRAY_COUNT; i++) begin
                if (wr_hit(board_ctrl_pkg::reg_addr_t'(`BC_REG_TEST_ARRAY + i))) begin
                    test_array[i] <= bus.wr_data;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------------
    always_comb begin
        rd_word = '0;
        case (bus.rd_addr)
            `BC_REG_FW_DATE:      rd_word = FW_DATE[DW-1:0];
            `BC_REG_FW_DATE + 1:  rd_word = FW_DATE[2*DW-1:DW];
            `BC_REG_FW_TIME:      rd_word = FW_TIME[DW-1:0];
            `BC_REG_FW_TIME + 1:  rd_word = FW_TIME[2*DW-1:DW];
            `BC_REG_FW_TYPE:      rd_word = `BC_FW_TYPE;
            `BC_REG_MAC_LINK:     rd_word = board_ctrl_pkg::reg_data_t'(mac_link_i);
            `BC_REG_PHY_RST:      rd_word = board_ctrl_pkg::reg_data_t'(eth_phy_rst_o);
            `BC_REG_MDIO_CLK:     rd_word = board_ctrl_pkg::reg_data_t'(eth_phy_mdc_o);
            `BC_REG_MDIO_DOUT:    rd_word = board_ctrl_pkg::reg_data_t'(eth_phy_mdio_o);
            `BC_REG_MDIO_DIR:     rd_word = board_ctrl_pkg::reg_data_t'(eth_phy_mdio_oe_o);
            `BC_REG_MDIO_DIN:     rd_word = board_ctrl_pkg::reg_data_t'(mdio_ff[1]);
            `BC_REG_LINK_STATUS:  rd_word = board_ctrl_pkg::reg_data_t'(link_channel_up_i);
            default: begin
                // counters are split low word first
                for (int p = 0; p < `BC_ETH_COUNT; p++) begin
                    if (bus.rd_addr == board_ctrl_pkg::reg_addr_t'(`BC_REG_RXERR0 + 2 * p)) begin
                        rd_word = mac_rx_cnterr_i[p][DW-1:0];
                    end
                    if (bus.rd_addr ==
                        board_ctrl_pkg::reg_addr_t'(`BC_REG_RXERR0 + 2 * p + 1)) begin
                        rd_word = mac_rx_cnterr_i[p][2*DW-1:DW];
                    end
                end
                for (int i = 0; i < `BC_TEST_ARRAY_COUNT; i++) begin
                    if (bus.rd_addr == board_ctrl_pkg::reg_addr_t'(`BC_REG_TEST_ARRAY + i)) begin
                        rd_word = test_array[i];
                    end
                end
            end
        endcase
    end

    assign bus.rd_data = rd_word;

endmodule

`default_nettype wire

/* logic/board_ctrl_top.sv */
/* Board-control top level. The MDIO tristate buffer lives outside,
   driven from eth_phy_mdio_o and eth_phy_mdio_oe_o. */
`timescale 1ns/1ps
`default_nettype none

`include "board_ctrl_defines.svh"

module board_ctrl_top #(
    parameter int unsigned BLINK_HALF_CYCLES = 62_500_000
) (
    input  wire                             reg_clk,
    input  wire                             arst_n_i,
    input  wire                             spi_cs_n_i,
    input  wire                             spi_clk_i,
    input  wire                             spi_mosi_i,
    output wire                             spi_miso_o,
    input  wire board_ctrl_pkg::eth_bits_t  mac_link_i,
    input  wire board_ctrl_pkg::err_cnt_t   mac_rx_cnterr_i [0:`BC_ETH_COUNT-1],
    input  wire [`BC_LINK_CH_COUNT-1:0]     link_channel_up_i,
    output wire board_ctrl_pkg::eth_bits_t  eth_phy_rst_o,
    output wire                             eth_phy_mdc_o,
    output wire                             eth_phy_mdio_o,
    output wire                             eth_phy_mdio_oe_o,
    input  wire                             eth_phy_mdio_i,
    output wire                             dbg_led_o
);

    reg_bus_if u_reg_bus ();

    spi_slave u_spi_slave (
        .reg_clk    (reg_clk),
        .arst_n_i   (arst_n_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_clk_i  (spi_clk_i),
        .spi_mosi_i (spi_mosi_i),
        .spi_miso_o (spi_miso_o),
        .bus        (u_reg_bus.master)
    );

    board_ctrl_regs u_board_ctrl_regs (
        .reg_clk           (reg_clk),
        .arst_n_i          (arst_n_i),
        .bus               (u_reg_bus.slave),
        .mac_link_i        (mac_link_i),
        .mac_rx_cnterr_i   (mac_rx_cnterr_i),
        .link_channel_up_i (link_channel_up_i),
        .eth_phy_mdio_i    (eth_phy_mdio_i),
        .eth_phy_rst_o     (eth_phy_rst_o),
        .eth_phy_mdc_o     (eth_phy_mdc_o),
        .eth_phy_mdio_o    (eth_phy_mdio_o),
        .eth_phy_mdio_oe_o (eth_phy_mdio_oe_o)
    );

    led_blink #(
        .BLINK_HALF_CYCLES (BLINK_HALF_CYCLES)
    ) u_led_blink (
        .reg_clk   (reg_clk),
        .arst_n_i  (arst_n_i),
        .dbg_led_o (dbg_led_o)
    );

endmodule

`default_nettype wire

/* logic/led_blink.sv */
/* Debug LED heartbeat, toggles every BLINK_HALF_CYCLES reg_clk cycles.
   BLINK_HALF_CYCLES must be at least 1. */
`timescale 1ns/1ps
`default_nettype none

module led_blink #(
    parameter int unsigned BLINK_HALF_CYCLES = 62_500_000
) (
    input  wire  reg_clk,
    input  wire  arst_n_i,
    output logic dbg_led_o
);

    localparam int unsigned CNT_W = (BLINK_HALF_CYCLES > 1) ? $clog2(BLINK_HALF_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BLINK_HALF_CYCLES - 1);

    logic [CNT_W-1:0] half_cnt;
    logic             terminal;

    assign terminal = (half_cnt == CNT_LAST);   // end of a half period

    // ------------------------------------------------------------------
    // half period counter
    // ------------------------------------------------------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            half_cnt  <= '0;
            dbg_led_o <= 1'b0;
        end else if (terminal) begin
            half_cnt  <= '0;
            dbg_led_o <= ~dbg_led_o;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/reg_bus_if.sv */
/* Register bus between the SPI slave and the register bank.
   wr_en is a one-cycle strobe, rd_data is combinational on rd_addr. */
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;

    logic                      wr_en;    // single reg_clk pulse
    board_ctrl_pkg::reg_addr_t wr_addr;
    board_ctrl_pkg::reg_data_t wr_data;
    board_ctrl_pkg::reg_addr_t rd_addr;
    board_ctrl_pkg::reg_data_t rd_data;

    modport master (
        output wr_en, wr_addr, wr_data, rd_addr,
        input  rd_data
    );

    modport slave (
        input  wr_en, wr_addr, wr_data, rd_addr,
        output rd_data
    );

endinterface

`default_nettype wire

/* logic/spi_slave.sv */
/* SPI mode 0 slave, MSB first, 24-bit frames. SPI clock high and low
   phases must each last at least 4 reg_clk cycles, all pins are
   resynchronized here. A frame cut short by cs is dropped. */
`timescale 1ns/1ps
`default_nettype none

`include "board_ctrl_defines.svh"

module spi_slave (
    input  wire       reg_clk,
    input  wire       arst_n_i,
    input  wire       spi_cs_n_i,
    input  wire       spi_clk_i,
    input  wire       spi_mosi_i,
    output logic      spi_miso_o,
    reg_bus_if.master bus
);

    localparam int unsigned FRAME_BITS = `BC_SPI_FRAME_BITS;
    localparam int unsigned DATA_BITS  = `BC_REG_DWIDTH;
    localparam int unsigned ADDR_BITS  = FRAME_BITS - DATA_BITS;   // flag + address
    localparam int unsigned CNT_W      = $clog2(FRAME_BITS);

    logic [1:0]                 cs_n_ff;
    logic [1:0]                 sclk_ff;
    logic [1:0]                 mosi_ff;
    logic                       sclk_d;
    logic                       cs_n_s;
    logic                       mosi_s;
    logic                       sclk_rise;
    logic                       sclk_fall;
    logic                       sample;
    logic                       rd_flag;
    logic                       addr_done;
    logic                       frame_done;
    logic                       rd_load;
    logic [CNT_W-1:0]           bit_cnt;
    board_ctrl_pkg::spi_state_e state;
    board_ctrl_pkg::reg_data_t  mosi_sr;
    board_ctrl_pkg::reg_data_t  rd_shift;
    board_ctrl_pkg::reg_addr_t  addr_next;

    // ------------------------------------------------------------------
    // pin synchronizers and clock edge detect
    // ------------------------------------------------------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cs_n_ff <= 2'b11;
            sclk_ff <= 2'b00;
            mosi_ff <= 2'b00;
            sclk_d  <= 1'b0;
        end else begin
            cs_n_ff <= {cs_n_ff[0], spi_cs_n_i};
            sclk_ff <= {sclk_ff[0], spi_clk_i};
            mosi_ff <= {mosi_ff[0], spi_mosi_i};
            sclk_d  <= sclk_ff[1];
        end
    end

    assign cs_n_s    = cs_n_ff[1];
    assign mosi_s    = mosi_ff[1];
    assign sclk_rise = sclk_ff[1] & ~sclk_d;
    assign sclk_fall = ~sclk_ff[1] & sclk_d;
    assign sample    = sclk_rise & ~cs_n_s;

    // first frame bit has been shifted up to here by the 8th sample
    assign rd_flag    = mosi_sr[ADDR_BITS-2];
    assign addr_next  = {{(`BC_REG_AWIDTH - ADDR_BITS + 1){1'b0}},
                         mosi_sr[ADDR_BITS-3:0], mosi_s};
    assign addr_done  = sample && (state == board_ctrl_pkg::SPI_ADDR) &&
                        (bit_cnt == CNT_W'(ADDR_BITS - 1));
    assign frame_done = sample && (state == board_ctrl_pkg::SPI_WDATA) &&
                        (bit_cnt == CNT_W'(FRAME_BITS - 1));

    // ------------------------------------------------------------------
    // frame FSM
    // ------------------------------------------------------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state      <= board_ctrl_pkg::SPI_IDLE;
            bit_cnt    <= '0;
            rd_load    <= 1'b0;
            bus.wr_en  <= 1'b0;
        end else begin
            bus.wr_en <= 1'b0;
            rd_load   <= 1'b0;
            if (cs_n_s) begin                      // also drops a partial frame
                state   <= board_ctrl_pkg::SPI_IDLE;
                bit_cnt <= '0;
            end else begin
                case (state)
                    board_ctrl_pkg::SPI_IDLE: begin
                        state   <= board_ctrl_pkg::SPI_ADDR;
                        bit_cnt <= '0;
                    end
                    board_ctrl_pkg::SPI_ADDR: begin
                        if (sample) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        if (addr_done && rd_flag) begin
                            state   <= board_ctrl_pkg::SPI_RDATA;
                            rd_load <= 1'b1;       // snapshot next cycle
                        end else if (addr_done) begin
                            state <= board_ctrl_pkg::SPI_WDATA;
                        end
                    end
                    board_ctrl_pkg::SPI_WDATA: begin
                        if (sample) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        if (frame_done) begin
                            bus.wr_en <= 1'b1;
                            state     <= board_ctrl_pkg::SPI_IDLE;
                        end
                    end
                    board_ctrl_pkg::SPI_RDATA: begin
                        if (sample) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        if (sample && (bit_cnt == CNT_W'(FRAME_BITS - 1))) begin
                            state <= board_ctrl_pkg::SPI_IDLE;
                        end
                    end
                    default: state <= board_ctrl_pkg::SPI_IDLE;
                endcase
            end
        end
    end

    // ------------------------------------------------------------------
    // shift registers and bus payload
    // ------------------------------------------------------------------
    always_ff @(posedge reg_clk) begin
        if (sample) begin
            mosi_sr <= {mosi_sr[DATA_BITS-2:0], mosi_s};
        end
        if (addr_done) begin
            bus.wr_addr <= addr_next;
            if (rd_flag) begin
                bus.rd_addr <= addr_next;
            end
        end
        if (frame_done) begin
            bus.wr_data <= {mosi_sr[DATA_BITS-2:0], mosi_s};
        end
        if (rd_load) begin
            rd_shift <= bus.rd_data;
        end else if (sclk_fall && (state == board_ctrl_pkg::SPI_RDATA) &&
                     (bit_cnt > CNT_W'(ADDR_BITS))) begin
            rd_shift <= {rd_shift[DATA_BITS-2:0], 1'b0};   // next bit after fall
        end
    end

    assign spi_miso_o = ~spi_cs_n_i & (state == board_ctrl_pkg::SPI_RDATA) &
                        rd_shift[DATA_BITS-1];

endmodule

`default_nettype wire

/* sim/board_ctrl_assertions.sv */
/* Concurrent checks on the register bus and the SPI pins, bound into
   spi_slave and sampled on reg_clk. Idle while reset is asserted. */
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_assertions (
    input wire reg_clk,
    input wire arst_n_i,
    input wire wr_en_i,
    input wire cs_n_sync_i,
    input wire spi_miso_i
);

    int unsigned fail_count = 0;

    // ------------------------------------------------------------------
    // register bus
    // ------------------------------------------------------------------
    wr_en_single_pulse: assert property (@(posedge reg_clk) disable iff (!arst_n_i)
        wr_en_i |=> !wr_en_i)
        else begin
            fail_count++;
            $error("wr_en high on two consecutive cycles");
        end

    wr_en_inside_frame: assert property (@(posedge reg_clk) disable iff (!arst_n_i)
        wr_en_i |-> !cs_n_sync_i)
        else begin
            fail_count++;
            $error("wr_en high while synchronized cs is high");
        end

    // ------------------------------------------------------------------
    // spi pins
    // ------------------------------------------------------------------
    miso_quiet_when_idle: assert property (@(posedge reg_clk) disable iff (!arst_n_i)
        cs_n_sync_i |-> !spi_miso_i)
        else begin
            fail_count++;
            $error("spi_miso_o high while synchronized cs is high");
        end

endmodule

bind spi_slave board_ctrl_assertions u_assertions (
    .reg_clk     (reg_clk),
    .arst_n_i    (arst_n_i),
    .wr_en_i     (bus.wr_en),
    .cs_n_sync_i (cs_n_s),
    .spi_miso_i  (spi_miso_o)
);

`default_nettype wire

/* sim/board_ctrl_vectors.txt */
# op addr value, hex: W write, R read and compare with value, A write cut after 12 bits
# addr is the 7-bit register index
R 00 0001
R 01 C0DE
R 02 4B1D
R 03 0000
R 04 00A5
R 05 000A
R 13 0002
R 12 0001
R 06 0005
R 07 0000
R 08 0007
R 09 0001
R 0A 0009
R 0B 0002
R 0C 000B
R 0D 0003
W 20 1234
W 21 4321
W 22 A5A5
W 23 5A5A
W 24 FFFF
W 25 8001
W 26 00FF
W 27 C3C3
R 20 1234
R 21 4321
R 22 A5A5
R 23 5A5A
R 24 FFFF
R 25 8001
R 26 00FF
R 27 C3C3
W 30 DEAD
R 30 0000
W 28 BEEF
R 28 0000
R 27 C3C3
R 0E 0000
W 0E FFF5
R 0E 0005
W 0F FFFF
R 0F 0001
W 10 0001
R 10 0001
W 11 0001
R 11 0001
A 0E 000A
R 0E 0005
A 23 FFFF
R 23 5A5A
W 10 0000
R 10 0000

/* sim/tb_board_ctrl.sv */
/* Testbench for board_ctrl_top. Replays sim/board_ctrl_vectors.txt,
   so it runs from the project root. SPI clock is 8 reg_clk per bit. */
`timescale 1ns/1ps
`default_nettype none

`include "board_ctrl_defines.svh"

module tb_board_ctrl;

    localparam int FRAME_BITS = `BC_SPI_FRAME_BITS;
    localparam int HALF_BIT   = 4;       // reg_clk cycles per spi clock phase
    localparam int TIMEOUT    = 200;     // cycles, any single wait
    localparam int BLINK      = 16;

    logic                      reg_clk;
    logic                      arst_n_i;
    logic                      spi_cs_n_i;
    logic                      spi_clk_i;
    logic                      spi_mosi_i;
    logic                      spi_miso_o;
    board_ctrl_pkg::eth_bits_t mac_link_i;
    board_ctrl_pkg::err_cnt_t  mac_rx_cnterr_i [0:`BC_ETH_COUNT-1];
    logic [`BC_LINK_CH_COUNT-1:0] link_channel_up_i;
    board_ctrl_pkg::eth_bits_t eth_phy_rst_o;
    logic                      eth_phy_mdc_o;
    logic                      eth_phy_mdio_o;
    logic                      eth_phy_mdio_oe_o;
    logic                      eth_phy_mdio_i;
    logic                      dbg_led_o;

    board_ctrl_top #(
        .BLINK_HALF_CYCLES (BLINK)
    ) u_board_ctrl_top (
        .reg_clk           (reg_clk),
        .arst_n_i          (arst_n_i),
        .spi_cs_n_i        (spi_cs_n_i),
        .spi_clk_i         (spi_clk_i),
        .spi_mosi_i        (spi_mosi_i),
        .spi_miso_o        (spi_miso_o),
        .mac_link_i        (mac_link_i),
        .mac_rx_cnterr_i   (mac_rx_cnterr_i),
        .link_channel_up_i (link_channel_up_i),
        .eth_phy_rst_o     (eth_phy_rst_o),
        .eth_phy_mdc_o     (eth_phy_mdc_o),
        .eth_phy_mdio_o    (eth_phy_mdio_o),
        .eth_phy_mdio_oe_o (eth_phy_mdio_oe_o),
        .eth_phy_mdio_i    (eth_phy_mdio_i),
        .dbg_led_o         (dbg_led_o)
    );

    initial begin
        reg_clk = 1'b0;
        forever #5 reg_clk = ~reg_clk;
    end

    // ------------------------------------------------------------------
    // failure and compare tasks
    // ------------------------------------------------------------------
    task automatic fail_now(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_reg(input string name, input board_ctrl_pkg::reg_data_t got,
                             input board_ctrl_pkg::reg_data_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bits(input string name, input board_ctrl_pkg::eth_bits_t got,
                              input board_ctrl_pkg::eth_bits_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s got %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s got %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_now($sformatf("mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    always @(posedge reg_clk) begin
        if (u_board_ctrl_top.u_spi_slave.u_assertions.fail_count != 0) begin
            fail_now("a bound assertion on the SPI slave failed");
        end
    end

    // ------------------------------------------------------------------
    // timing and spi master
    // ------------------------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge reg_clk);
        end
        #1;                                  // drive point after the edge
    endtask

    task automatic count_until_led(input logic level, output int cycles);
        cycles = 0;
        while (dbg_led_o !== level) begin
            wait_cycles(1);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_now("dbg_led_o did not toggle within the timeout");
            end
        end
    endtask

    // mode 0, msb first; nbits below FRAME_BITS cuts the frame short
    task automatic spi_frame(input logic rd, input board_ctrl_pkg::reg_addr_t addr,
                             input board_ctrl_pkg::reg_data_t wdata, input int nbits,
                             output board_ctrl_pkg::reg_data_t rdata);
        logic [FRAME_BITS-1:0] frame;
        frame = {rd, addr[FRAME_BITS-`BC_REG_DWIDTH-2:0], wdata};
        rdata = '0;
        spi_cs_n_i = 1'b0;
        for (int i = FRAME_BITS - 1; i >= FRAME_BITS - nbits; i--) begin
            spi_mosi_i = frame[i];
            wait_cycles(HALF_BIT);
            if (i < `BC_REG_DWIDTH) begin
                rdata[i] = spi_miso_o;       // master samples before rising edge
            end
            spi_clk_i = 1'b1;
            wait_cycles(HALF_BIT);
            spi_clk_i = 1'b0;
        end
        wait_cycles(HALF_BIT);
        spi_cs_n_i = 1'b1;
        spi_mosi_i = 1'b0;
        wait_cycles(HALF_BIT);
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        int                        fd;
        int                        nfields;
        int                        nvec;
        int                        cycles;
        string                     line;
        byte                       op;
        board_ctrl_pkg::reg_addr_t addr;
        board_ctrl_pkg::reg_data_t value;
        board_ctrl_pkg::reg_data_t got;

        arst_n_i       = 1'b0;
        spi_cs_n_i     = 1'b1;
        spi_clk_i      = 1'b0;
        spi_mosi_i     = 1'b0;
        mac_link_i     = 4'b1010;
        eth_phy_mdio_i = 1'b1;
        link_channel_up_i = 2'b10;
        for (int p = 0; p < `BC_ETH_COUNT; p++) begin
            mac_rx_cnterr_i[p] = board_ctrl_pkg::err_cnt_t'(32'h0001_0002 * p + 5);
        end
        wait_cycles(3);
        arst_n_i = 1'b1;

        check_bits("eth_phy_rst_o", eth_phy_rst_o, '0);
        check_bit("eth_phy_mdc_o", eth_phy_mdc_o, 1'b0);
        check_bit("eth_phy_mdio_o", eth_phy_mdio_o, 1'b0);
        check_bit("eth_phy_mdio_oe_o", eth_phy_mdio_oe_o, 1'b0);
        check_bit("spi_miso_o", spi_miso_o, 1'b0);
        check_bit("dbg_led_o", dbg_led_o, 1'b0);

        // heartbeat, counted from reset release
        count_until_led(1'b1, cycles);
        check_count("dbg_led_o first rise, cycles", cycles, BLINK);
        count_until_led(1'b0, cycles);
        check_count("dbg_led_o half period, cycles", cycles, BLINK);
        count_until_led(1'b1, cycles);
        check_count("dbg_led_o half period, cycles", cycles, BLINK);

        fd = $fopen("sim/board_ctrl_vectors.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open sim/board_ctrl_vectors.txt");
        end
        nvec = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            nfields = $sscanf(line, " %c %h %h", op, addr, value);
            if (nfields < 1) begin
                continue;
            end
            if (nfields != 3) begin
                fail_now($sformatf("malformed vector line: %s", line));
            end
            nvec++;
            case (op)
                "W": begin
                    spi_frame(1'b0, addr, value, FRAME_BITS, got);
                    if (addr == `BC_REG_PHY_RST) begin
                        check_bits("eth_phy_rst_o", eth_phy_rst_o, value[`BC_ETH_COUNT-1:0]);
                    end
                    if (addr == `BC_REG_MDIO_CLK) begin
                        check_bit("eth_phy_mdc_o", eth_phy_mdc_o, value[0]);
                    end
                    if (addr == `BC_REG_MDIO_DOUT) begin
                        check_bit("eth_phy_mdio_o", eth_phy_mdio_o, value[0]);
                    end
                    if (addr == `BC_REG_MDIO_DIR) begin
                        check_bit("eth_phy_mdio_oe_o", eth_phy_mdio_oe_o, value[0]);
                    end
                end
                "A": spi_frame(1'b0, addr, value, 12, got);     // cs rises after 12 bits
                "R": begin
                    spi_frame(1'b1, addr, '0, FRAME_BITS, got);
                    check_reg($sformatf("spi read of register 0x%02h", addr), got, value);
                end
                default: fail_now($sformatf("unknown operation in vector line: %s", line));
            endcase
        end
        $fclose(fd);
        if (nvec == 0) begin
            fail_now("no vectors found in sim/board_ctrl_vectors.txt");
        end

        if (u_board_ctrl_top.u_spi_slave.u_assertions.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
